// File: rtl/red_ctrl_pkg.sv
/* Control path definitions for the row reduction unit.
   Operation select and the type of the row-length count. */
package red_ctrl_pkg;

  // Reduction applied to every lane of a row
  typedef enum logic {
    RED_SUM = 1'b0,
    RED_MAX = 1'b1
  } red_op_e;

  // Beats per row, legal range 1 to 255
  localparam int unsigned ROW_LEN_W = 8;

  typedef logic [ROW_LEN_W-1:0] row_len_t;

endpackage

// File: rtl/red_data_pkg.sv
/* Data path definitions for the row reduction unit.
   Lane count, element and vector types, and the neutral values of each operation. */
package red_data_pkg;

  // One lane per output row
  localparam int unsigned WIDTH = 4;

  localparam int unsigned ELEM_W = 16;

  // Signed element, also the width of a row result
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Lane i sits at index i
  typedef elem_t [WIDTH-1:0] vec_t;

  // Neutral element of the wrapping sum
  localparam elem_t SUM_NEUTRAL = '0;

  // Neutral element of the signed maximum
  localparam elem_t MAX_NEUTRAL = {1'b1, {(ELEM_W-1){1'b0}}};

endpackage

// File: rtl/red_max_lanes.sv
/* Per-lane signed maximum registers that build the row maxima.
   Driven by the same strobes as the sum lanes, side by side with them. */
`timescale 1ns/1ps

module red_max_lanes (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               start_i,
  input  logic               seed_i,
  input  logic               acc_en_i,
  input  red_data_pkg::vec_t init_i,
  input  red_data_pkg::vec_t data_i,
  output red_data_pkg::vec_t max_o
);

  for (genvar i = 0; i < red_data_pkg::WIDTH; i++) begin : gen_lane
    red_data_pkg::elem_t max_q;
    red_data_pkg::elem_t din;
    red_data_pkg::elem_t larger;

    // Both operands signed, so the compare is signed
    assign din    = data_i[i];
    assign larger = (din > max_q) ? din : max_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        max_q <= '0;
      end else if (clear_i) begin
        max_q <= '0;
      end else if (start_i) begin
        max_q <= red_data_pkg::MAX_NEUTRAL;
      end else if (seed_i) begin
        max_q <= init_i[i];
      end else if (acc_en_i) begin
        max_q <= larger;
      end
    end

    assign max_o[i] = max_q;
  end

  strobe_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({start_i, seed_i, acc_en_i})
  ) else $error("max lanes got more than one strobe in a cycle");

endmodule

// File: rtl/red_reduction_unit.sv
/* Row-wise reduction unit for the output side of a matrix engine.
   Sum and max lanes run side by side, the row controller sequences both and selects the result. */
`timescale 1ns/1ps

module red_reduction_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   enable_i,
  input  red_ctrl_pkg::red_op_e  op_i,
  input  red_ctrl_pkg::row_len_t row_len_i,
  input  logic                   load_i,
  input  red_data_pkg::vec_t     init_i,
  input  logic                   init_valid_i,
  input  logic                   valid_i,
  input  red_data_pkg::vec_t     data_i,
  input  logic                   ready_i,
  output red_data_pkg::vec_t     red_o,
  output logic                   red_valid_o,
  output logic                   is_init_o
);

  logic start;
  logic seed;
  logic acc_en;

  red_data_pkg::vec_t sum_q;
  red_data_pkg::vec_t max_q;

  red_row_ctrl i_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .enable_i     (enable_i),
    .op_i         (op_i),
    .row_len_i    (row_len_i),
    .load_i       (load_i),
    .init_valid_i (init_valid_i),
    .valid_i      (valid_i),
    .ready_i      (ready_i),
    .sum_i        (sum_q),
    .max_i        (max_q),
    .start_o      (start),
    .seed_o       (seed),
    .acc_en_o     (acc_en),
    .red_valid_o  (red_valid_o),
    .is_init_o    (is_init_o),
    .red_o        (red_o)
  );

  red_sum_lanes i_sum (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .start_i  (start),
    .seed_i   (seed),
    .acc_en_i (acc_en),
    .init_i   (init_i),
    .data_i   (data_i),
    .sum_o    (sum_q)
  );

  red_max_lanes i_max (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .start_i  (start),
    .seed_i   (seed),
    .acc_en_i (acc_en),
    .init_i   (init_i),
    .data_i   (data_i),
    .max_o    (max_q)
  );

endmodule

// File: rtl/red_row_ctrl.sv
/* Row controller of the reduction unit.
   Initializes the lanes, counts beats, holds the result valid and picks the output vector. */
`timescale 1ns/1ps

module red_row_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   enable_i,
  input  red_ctrl_pkg::red_op_e  op_i,
  input  red_ctrl_pkg::row_len_t row_len_i,
  input  logic                   load_i,
  input  logic                   init_valid_i,
  input  logic                   valid_i,
  input  logic                   ready_i,
  input  red_data_pkg::vec_t     sum_i,
  input  red_data_pkg::vec_t     max_i,
  output logic                   start_o,
  output logic                   seed_o,
  output logic                   acc_en_o,
  output logic                   red_valid_o,
  output logic                   is_init_o,
  output red_data_pkg::vec_t     red_o
);

  logic                   is_init_q;
  logic                   red_valid_q;
  red_ctrl_pkg::row_len_t beat_cnt_q;

  logic init_req;
  logic last_beat;
  logic handshake;

  // Lanes get initialized once per row, before the first beat
  assign init_req = enable_i && !is_init_q && !clear_i;
  assign start_o  = init_req && !load_i;
  assign seed_o   = init_req && load_i && init_valid_i;

  // Beats only count between initialization and the result
  assign acc_en_o  = valid_i && is_init_q && !red_valid_q && !clear_i;
  assign last_beat = acc_en_o && (beat_cnt_q == row_len_i - 1'b1);
  assign handshake = red_valid_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      is_init_q <= 1'b0;
    end else if (clear_i) begin
      is_init_q <= 1'b0;
    end else if (start_o || seed_o) begin
      is_init_q <= 1'b1;
    end else if (handshake) begin
      is_init_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (clear_i || last_beat) begin
      beat_cnt_q <= '0;
    end else if (acc_en_o) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // Result stays valid until the consumer takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      red_valid_q <= 1'b0;
    end else if (clear_i || handshake) begin
      red_valid_q <= 1'b0;
    end else if (last_beat) begin
      red_valid_q <= 1'b1;
    end
  end

  assign red_valid_o = red_valid_q;
  assign is_init_o   = is_init_q;

  assign red_o = (op_i == red_ctrl_pkg::RED_MAX) ? max_i : sum_i;

  // Producer must hold off while a result waits
  no_beat_on_result_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    red_valid_q |-> !valid_i
  ) else $error("valid_i beat while a result is pending");

  row_len_nonzero_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    enable_i |-> (row_len_i != '0)
  ) else $error("row_len_i is zero while enabled");

endmodule

// File: rtl/red_sum_lanes.sv
/* Per-lane wrapping accumulators that build the row sums.
   Sequenced by the row controller through its start, seed and accumulate strobes. */
`timescale 1ns/1ps

module red_sum_lanes (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               start_i,
  input  logic               seed_i,
  input  logic               acc_en_i,
  input  red_data_pkg::vec_t init_i,
  input  red_data_pkg::vec_t data_i,
  output red_data_pkg::vec_t sum_o
);

  for (genvar i = 0; i < red_data_pkg::WIDTH; i++) begin : gen_lane
    red_data_pkg::elem_t acc_q;
    red_data_pkg::elem_t acc_next;

    // Sum wraps modulo 2^16
    assign acc_next = acc_q + data_i[i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        acc_q <= '0;
      end else if (clear_i) begin
        acc_q <= '0;
      end else if (start_i) begin
        acc_q <= red_data_pkg::SUM_NEUTRAL;
      end else if (seed_i) begin
        acc_q <= init_i[i];
      end else if (acc_en_i) begin
        acc_q <= acc_next;
      end
    end

    assign sum_o[i] = acc_q;
  end

  // Controller issues at most one strobe per cycle
  strobe_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({start_i, seed_i, acc_en_i})
  ) else $error("sum lanes got more than one strobe in a cycle");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the reduction unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_red_reduction_unit \
  -f sources.f -o tb_sim

out=$(./obj_dir/tb_sim || true)
echo "$out"

if echo "$out" | grep -q "Test passed"; then
  exit 0
fi
exit 1

// File: sources.f
+incdir+test
rtl/red_data_pkg.sv
rtl/red_ctrl_pkg.sv
rtl/red_sum_lanes.sv
rtl/red_max_lanes.sv
rtl/red_row_ctrl.sv
rtl/red_reduction_unit.sv
test/tb_red_reduction_unit.sv

// File: test/red_tests.svh
/* Directed tests for the row reduction unit, included by the testbench module.
   run_row sends the beats queued in row_data and checks the held result. */

  function automatic red_data_pkg::vec_t make_vec(input int base, input int lane_step);
    red_data_pkg::vec_t v;
    for (int l = 0; l < red_data_pkg::WIDTH; l++) begin
      v[l] = red_data_pkg::elem_t'(base + l * lane_step);
    end
    return v;
  endfunction

  task automatic make_row(input int len, input int base, input int step, input int lane_step);
    row_data.delete();
    for (int k = 0; k < len; k++) begin
      row_data.push_back(make_vec(base + k * step, lane_step));
    end
  endtask

  task automatic run_row(input string name, input red_ctrl_pkg::red_op_e op,
                         input logic use_seed, input red_data_pkg::vec_t seed, input int hold);
    red_data_pkg::vec_t expected;
    int len;
    len = row_data.size();
    // Neutral start is zero for the sum and the most negative value for the maximum
    for (int l = 0; l < red_data_pkg::WIDTH; l++) begin
      if (use_seed) begin
        expected[l] = seed[l];
      end else if (op == red_ctrl_pkg::RED_MAX) begin
        expected[l] = red_data_pkg::elem_t'(-32768);
      end else begin
        expected[l] = '0;
      end
    end
    @(negedge clk_i);
    op_i         = op;
    row_len_i    = red_ctrl_pkg::row_len_t'(len);
    load_i       = use_seed;
    init_i       = seed;
    init_valid_i = use_seed;
    enable_i     = 1'b1;
    wait_init(name);
    init_valid_i = 1'b0;
    for (int k = 0; k < len; k++) begin
      valid_i = 1'b1;
      data_i  = row_data[k];
      for (int l = 0; l < red_data_pkg::WIDTH; l++) begin
        expected[l] = fold_elem(op, expected[l], row_data[k][l]);
      end
      @(negedge clk_i);
    end
    valid_i = 1'b0;
    data_i  = '0;
    wait_result(name, len);
    check_vec(name, expected, red_o);
    check_bit({name, " is_init"}, 1'b1, is_init_o);
    repeat (hold) begin
      @(negedge clk_i);
      check_bit({name, " held valid"}, 1'b1, red_valid_o);
      check_vec({name, " held result"}, expected, red_o);
    end
    ready_i = 1'b1;
    @(negedge clk_i);
    ready_i  = 1'b0;
    enable_i = 1'b0;
    check_bit({name, " valid after ready"}, 1'b0, red_valid_o);
    check_bit({name, " is_init after ready"}, 1'b0, is_init_o);
  endtask

  task automatic test_sum_neutral();
    // Large steps so the sums wrap
    make_row(6, 4660, 4660, 3857);
    run_row("sum_neutral", red_ctrl_pkg::RED_SUM, 1'b0, '0, 0);
  endtask

  task automatic test_max_neutral();
    // Every lane stays negative so a zero start would win
    make_row(6, -30000, 900, 211);
    run_row("max_neutral", red_ctrl_pkg::RED_MAX, 1'b0, '0, 0);
  endtask

  task automatic test_seeded();
    @(negedge clk_i);
    op_i         = red_ctrl_pkg::RED_SUM;
    row_len_i    = red_ctrl_pkg::row_len_t'(4);
    load_i       = 1'b1;
    init_valid_i = 1'b0;
    enable_i     = 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      check_bit("seeded waits for init_valid", 1'b0, is_init_o);
    end
    make_row(4, 100, 50, -30);
    run_row("seeded_sum", red_ctrl_pkg::RED_SUM, 1'b1, make_vec(-7000, 2500), 0);
    // Seed wins in the upper lanes and data in the lower ones
    make_row(5, -500, 120, 40);
    run_row("seeded_max", red_ctrl_pkg::RED_MAX, 1'b1, make_vec(-200, 150), 0);
  endtask

  task automatic test_hold_and_chain();
    make_row(7, 321, -77, 1999);
    run_row("hold", red_ctrl_pkg::RED_SUM, 1'b0, '0, 8);
    make_row(3, 12000, -6000, -999);
    run_row("chain_first", red_ctrl_pkg::RED_MAX, 1'b0, '0, 0);
    make_row(9, -3000, 1234, 777);
    run_row("chain_second", red_ctrl_pkg::RED_SUM, 1'b0, '0, 0);
  endtask

  task automatic test_clear();
    @(negedge clk_i);
    op_i      = red_ctrl_pkg::RED_SUM;
    row_len_i = red_ctrl_pkg::row_len_t'(8);
    load_i    = 1'b0;
    enable_i  = 1'b1;
    wait_init("clear");
    for (int k = 0; k < 4; k++) begin
      valid_i = 1'b1;
      data_i  = make_vec(1000 + k * 100, 3);
      @(negedge clk_i);
    end
    valid_i = 1'b0;
    clear_i = 1'b1;
    @(negedge clk_i);
    check_bit("clear valid", 1'b0, red_valid_o);
    check_bit("clear is_init", 1'b0, is_init_o);
    check_vec("clear sum lanes", '0, red_o);
    op_i = red_ctrl_pkg::RED_MAX;
    @(negedge clk_i);
    check_vec("clear max lanes", '0, red_o);
    clear_i  = 1'b0;
    enable_i = 1'b0;
    make_row(5, 42, 17, -9);
    run_row("clear_fresh", red_ctrl_pkg::RED_SUM, 1'b0, '0, 0);
    // Clear also drops a result that still waits for ready
    @(negedge clk_i);
    row_len_i = red_ctrl_pkg::row_len_t'(2);
    enable_i  = 1'b1;
    wait_init("clear pending");
    for (int k = 0; k < 2; k++) begin
      valid_i = 1'b1;
      data_i  = make_vec(k + 5, 1);
      @(negedge clk_i);
    end
    valid_i = 1'b0;
    data_i  = '0;
    wait_result("clear pending", 2);
    clear_i  = 1'b1;
    enable_i = 1'b0;
    @(negedge clk_i);
    clear_i = 1'b0;
    check_bit("clear pending valid", 1'b0, red_valid_o);
    check_bit("clear pending is_init", 1'b0, is_init_o);
    check_vec("clear pending result", '0, red_o);
  endtask

  task automatic test_random_rows();
    red_ctrl_pkg::red_op_e op;
    red_data_pkg::vec_t    seed;
    logic                  use_seed;
    int                    len;
    for (int r = 0; r < 10; r++) begin
      op       = rand_bits(1) == 1 ? red_ctrl_pkg::RED_MAX : red_ctrl_pkg::RED_SUM;
      len      = int'(rand_bits(4)) + 1;
      use_seed = rand_bits(1) == 1;
      for (int l = 0; l < red_data_pkg::WIDTH; l++) begin
        seed[l] = red_data_pkg::elem_t'(rand_bits(16));
      end
      row_data.delete();
      for (int k = 0; k < len; k++) begin
        row_data.push_back(make_vec(int'(rand_bits(16)), int'(rand_bits(16))));
      end
      run_row($sformatf("random_row_%0d", r), op, use_seed, seed, int'(rand_bits(2)));
    end
  endtask

// File: test/tb_red_reduction_unit.sv
/* Testbench for the row reduction unit.
   Drives dut0 on falling edges and checks each row against a per-lane model. */
`timescale 1ns/1ps

module tb_red_reduction_unit;

  localparam int unsigned CLK_PERIOD = 100;
  // (row_len + 20) cycles per row of every test plus reset and margin
  localparam int unsigned WATCHDOG_CYCLES = (6 + 20) + (6 + 20) + 2 * (5 + 20)
      + 3 * (9 + 20) + 3 * (8 + 20) + 10 * (16 + 20) + 200;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   clear_i;
  logic                   enable_i;
  red_ctrl_pkg::red_op_e  op_i;
  red_ctrl_pkg::row_len_t row_len_i;
  logic                   load_i;
  red_data_pkg::vec_t     init_i;
  logic                   init_valid_i;
  logic                   valid_i;
  red_data_pkg::vec_t     data_i;
  logic                   ready_i;
  red_data_pkg::vec_t     red_o;
  logic                   red_valid_o;
  logic                   is_init_o;

  // Beats of the row that run_row sends next
  red_data_pkg::vec_t row_data[$];
  logic [31:0]        lfsr_q;

  red_reduction_unit dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .enable_i     (enable_i),
    .op_i         (op_i),
    .row_len_i    (row_len_i),
    .load_i       (load_i),
    .init_i       (init_i),
    .init_valid_i (init_valid_i),
    .valid_i      (valid_i),
    .data_i       (data_i),
    .ready_i      (ready_i),
    .red_o        (red_o),
    .red_valid_o  (red_valid_o),
    .is_init_o    (is_init_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      if (lfsr_q[0]) begin
        lfsr_q = (lfsr_q >> 1) ^ 32'ha300_0000;
      end else begin
        lfsr_q = lfsr_q >> 1;
      end
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Lane model with a wrapping sum or a signed maximum
  function automatic red_data_pkg::elem_t fold_elem(input red_ctrl_pkg::red_op_e op,
                                                    input red_data_pkg::elem_t acc,
                                                    input red_data_pkg::elem_t d);
    int wide;
    if (op == red_ctrl_pkg::RED_MAX) begin
      if (int'(d) > int'(acc)) begin
        return d;
      end
      return acc;
    end
    wide = (int'(acc) + int'(d)) & 32'h0000_ffff;
    return red_data_pkg::elem_t'(wide);
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_vec(input string name, input red_data_pkg::vec_t exp,
                           input red_data_pkg::vec_t act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic wait_init(input string name);
    int n;
    n = 0;
    while (!is_init_o) begin
      if (n >= 16) begin
        $display("%s: the unit never finished initialization", name);
        abort_run();
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic wait_result(input string name, input int len);
    int n;
    n = 0;
    while (!red_valid_o) begin
      if (n >= 2 * len + 10) begin
        $display("%s: no result arrived after %0d cycles", name, n);
        abort_run();
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  `include "red_tests.svh"

  initial begin
    lfsr_q       = 32'h3ec9;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    enable_i     = 1'b0;
    op_i         = red_ctrl_pkg::RED_SUM;
    row_len_i    = red_ctrl_pkg::row_len_t'(1);
    load_i       = 1'b0;
    init_i       = '0;
    init_valid_i = 1'b0;
    valid_i      = 1'b0;
    data_i       = '0;
    ready_i      = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_vec("reset", '0, red_o);
    check_bit("reset valid", 1'b0, red_valid_o);
    check_bit("reset is_init", 1'b0, is_init_o);
    test_sum_neutral();
    test_max_neutral();
    test_seeded();
    test_hold_and_chain();
    test_clear();
    test_random_rows();
    $display("Test passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    abort_run();
  end

endmodule
